//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0 -Wno-fatal
LINT      = --lint-only --timing -Wall
TOP       = rob_tb
RTL_TOP   = rob_top
FILELIST  = project.f
BUILD     = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q -F '** PASS **'

lint:
	$(VERILATOR) $(LINT) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)

//--- design/rename_regfile.sv
`timescale 1ns/1ns
`include "rob_config.svh"

module rename_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  alloc_fire,
    input  rob_pkg::dispatch_t    alloc,
    input  rob_pkg::rob_tag_t     alloc_tag,
    input  logic                  commit_valid,
    input  rob_pkg::commit_t      commit,
    input  logic                  flush,
    input  logic [`REG_IDX_W-1:0] rs_idx,
    output logic [`XLEN-1:0]      rs_value,
    output logic                  rs_busy,
    output rob_pkg::rob_tag_t     rs_tag
);

    logic [`XLEN-1:0]     regs [`NUM_REGS];
    logic [`NUM_REGS-1:0] busy;
    rob_pkg::rob_tag_t    tags [`NUM_REGS];
    logic                 rename_rd;
    logic                 release_rd;

    // x0 is never renamed
    assign rename_rd = alloc_fire && (alloc.rd != '0);

    // only the latest producer frees the register
    assign release_rd = commit_valid && busy[commit.rd] && (tags[commit.rd] == commit.tag)
                        && !(rename_rd && (alloc.rd == commit.rd));

    assign rs_value = regs[rs_idx];
    assign rs_busy  = busy[rs_idx];
    assign rs_tag   = tags[rs_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_valid && (commit.rd != '0)) begin
            // a mispredicted branch still writes its rd
            regs[commit.rd] <= commit.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= '0;
        end else begin
            if (release_rd) begin
                busy[commit.rd] <= 1'b0;
            end
            if (rename_rd) begin
                busy[alloc.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rename_rd) begin
            tags[alloc.rd] <= alloc_tag;
        end
    end

endmodule

//--- design/rob_commit.sv
`timescale 1ns/1ns
`include "rob_config.svh"

module rob_commit (
    input  logic                clk,
    input  logic                rst,
    input  rob_pkg::rob_entry_t head_entry,
    input  logic                lsu_done_valid,
    input  rob_pkg::lsu_done_t  lsu_done,
    output rob_pkg::rob_tag_t   head_ptr,
    output logic                retire,
    output logic                commit_valid,
    output rob_pkg::commit_t    commit,
    output logic                flush,
    output logic [`XLEN-1:0]    redirect_pc,
    output logic                store_release,
    output rob_pkg::rob_tag_t   store_tag
);

    // head store has been released, waiting on the lsu
    logic store_waiting;
    logic head_store;
    logic alu_retire;
    logic store_retire;
    logic do_release;
    logic mispredict;

    assign head_store = head_entry.valid && head_entry.is_store;

    // nothing behind a mispredicted branch may retire
    assign alu_retire = head_entry.valid && head_entry.done && !head_entry.is_store && !flush;

    assign store_retire = head_store && store_waiting && !flush
                          && lsu_done_valid && (lsu_done.tag == head_ptr);

    assign do_release = head_store && !store_waiting && !flush;

    assign mispredict = head_entry.is_branch && (head_entry.taken != head_entry.pred_taken);

    assign retire = alu_retire || store_retire;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_ptr <= '0;
        end else if (retire) begin
            head_ptr <= head_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid  <= 1'b0;
            flush         <= 1'b0;
            store_release <= 1'b0;
            store_waiting <= 1'b0;
        end else begin
            commit_valid  <= alu_retire;
            flush         <= alu_retire && mispredict;
            store_release <= do_release;
            if (flush || store_retire) begin
                store_waiting <= 1'b0;
            end else if (do_release) begin
                store_waiting <= 1'b1;
            end
        end
    end

    // write-back and redirect payload
    always_ff @(posedge clk) begin
        if (alu_retire) begin
            commit.rd   <= head_entry.rd;
            commit.tag  <= head_ptr;
            commit.data <= head_entry.data;
            redirect_pc <= head_entry.target;
        end
        if (do_release) begin
            store_tag <= head_ptr;
        end
    end

endmodule

//--- design/rob_config.svh
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// reorder buffer entries, a power of two
`define ROB_DEPTH 16

// tag indexes one entry
`define ROB_TAG_W 4

// data and branch target width
`define XLEN 32

// architectural register index
`define REG_IDX_W 5

// x0 through x31
`define NUM_REGS 32

`endif

//--- design/rob_entries.sv
`timescale 1ns/1ns
`include "rob_config.svh"

module rob_entries (
    input  logic                clk,
    input  logic                rst,
    input  logic                alloc_fire,
    input  rob_pkg::rob_tag_t   alloc_tag,
    input  rob_pkg::dispatch_t  alloc,
    input  logic                ex_done_valid,
    input  rob_pkg::ex_done_t   ex_done,
    input  logic                lsu_done_valid,
    input  rob_pkg::lsu_done_t  lsu_done,
    input  rob_pkg::rob_tag_t   head_ptr,
    input  logic                retire,
    input  logic                flush,
    output rob_pkg::rob_entry_t head_entry
);

    rob_pkg::rob_entry_t entries [`ROB_DEPTH];

    assign head_entry = entries[head_ptr];

    // valid and done are control state
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].done  <= 1'b0;
            end
        end else begin
            if (retire) begin
                entries[head_ptr].valid <= 1'b0;
                entries[head_ptr].done  <= 1'b0;
            end
            if (alloc_fire) begin
                entries[alloc_tag].valid <= 1'b1;
                entries[alloc_tag].done  <= 1'b0;
            end
            // both ports may hit different tags in one cycle
            if (ex_done_valid) begin
                entries[ex_done.tag].done <= 1'b1;
            end
            if (lsu_done_valid) begin
                entries[lsu_done.tag].done <= 1'b1;
            end
        end
    end

    // payload fields by tag
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            entries[alloc_tag].rd         <= alloc.rd;
            entries[alloc_tag].is_store   <= alloc.is_store;
            entries[alloc_tag].is_branch  <= alloc.is_branch;
            entries[alloc_tag].pred_taken <= alloc.pred_taken;
            entries[alloc_tag].taken      <= 1'b0;
        end
        if (ex_done_valid) begin
            entries[ex_done.tag].data   <= ex_done.data;
            entries[ex_done.tag].taken  <= ex_done.taken;
            entries[ex_done.tag].target <= ex_done.target;
        end
        if (lsu_done_valid) begin
            entries[lsu_done.tag].data <= lsu_done.data;
        end
    end

endmodule

//--- design/rob_pkg.sv
`include "rob_config.svh"

package rob_pkg;

    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    // fields from the dispatch stage
    typedef struct packed {
        logic [`REG_IDX_W-1:0] rd;
        logic                  is_store;
        logic                  is_branch;
        logic                  pred_taken;
    } dispatch_t;

    // alu result, branch outcome included
    typedef struct packed {
        rob_tag_t          tag;
        logic [`XLEN-1:0]  data;
        logic              taken;
        logic [`XLEN-1:0]  target;
    } ex_done_t;

    // load data or store confirmation
    typedef struct packed {
        rob_tag_t          tag;
        logic [`XLEN-1:0]  data;
    } lsu_done_t;

    typedef struct packed {
        logic                  valid;
        logic                  done;
        logic [`REG_IDX_W-1:0] rd;
        logic                  is_store;
        logic                  is_branch;
        logic                  pred_taken;
        logic [`XLEN-1:0]      data;
        logic                  taken;
        logic [`XLEN-1:0]      target;
    } rob_entry_t;

    // architectural register write-back
    typedef struct packed {
        logic [`REG_IDX_W-1:0] rd;
        rob_tag_t              tag;
        logic [`XLEN-1:0]      data;
    } commit_t;

endpackage

//--- design/rob_tag_alloc.sv
`timescale 1ns/1ns
`include "rob_config.svh"

module rob_tag_alloc (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc_valid,
    input  logic              retire,
    input  logic              flush,
    output logic              alloc_ready,
    output rob_pkg::rob_tag_t alloc_tag,
    output logic              alloc_fire
);

    localparam logic [`ROB_TAG_W:0] DEPTH = `ROB_DEPTH;

    rob_pkg::rob_tag_t   tail;
    logic [`ROB_TAG_W:0] count;
    logic                full;

    assign full        = (count == DEPTH);
    // nothing is accepted while the buffer drains on a flush
    assign alloc_ready = !full && !flush;
    assign alloc_fire  = alloc_valid && alloc_ready;
    assign alloc_tag   = tail;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail <= '0;
        end else if (alloc_fire) begin
            // wraps with the tag width
            tail <= tail + 1'b1;
        end
    end

    // occupancy, allocate and retire may coincide
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            count <= '0;
        end else begin
            case ({alloc_fire, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- design/rob_top.sv
`timescale 1ns/1ns
`include "rob_config.svh"

module rob_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  alloc_valid,
    input  rob_pkg::dispatch_t    alloc,
    output logic                  alloc_ready,
    output rob_pkg::rob_tag_t     alloc_tag,
    input  logic                  ex_done_valid,
    input  rob_pkg::ex_done_t     ex_done,
    input  logic                  lsu_done_valid,
    input  rob_pkg::lsu_done_t    lsu_done,
    output logic                  commit_valid,
    output rob_pkg::commit_t      commit,
    output logic                  flush,
    output logic [`XLEN-1:0]      redirect_pc,
    output logic                  store_release,
    output rob_pkg::rob_tag_t     store_tag,
    input  logic [`REG_IDX_W-1:0] rs_idx,
    output logic [`XLEN-1:0]      rs_value,
    output logic                  rs_busy,
    output rob_pkg::rob_tag_t     rs_tag
);

    logic                alloc_fire;
    logic                retire;
    rob_pkg::rob_tag_t   head_ptr;
    rob_pkg::rob_entry_t head_entry;

    rob_tag_alloc u_tag_alloc (
        .clk         (clk),
        .rst         (rst),
        .alloc_valid (alloc_valid),
        .retire      (retire),
        .flush       (flush),
        .alloc_ready (alloc_ready),
        .alloc_tag   (alloc_tag),
        .alloc_fire  (alloc_fire)
    );

    rob_entries u_entries (
        .clk            (clk),
        .rst            (rst),
        .alloc_fire     (alloc_fire),
        .alloc_tag      (alloc_tag),
        .alloc          (alloc),
        .ex_done_valid  (ex_done_valid),
        .ex_done        (ex_done),
        .lsu_done_valid (lsu_done_valid),
        .lsu_done       (lsu_done),
        .head_ptr       (head_ptr),
        .retire         (retire),
        .flush          (flush),
        .head_entry     (head_entry)
    );

    rob_commit u_commit (
        .clk            (clk),
        .rst            (rst),
        .head_entry     (head_entry),
        .lsu_done_valid (lsu_done_valid),
        .lsu_done       (lsu_done),
        .head_ptr       (head_ptr),
        .retire         (retire),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .flush          (flush),
        .redirect_pc    (redirect_pc),
        .store_release  (store_release),
        .store_tag      (store_tag)
    );

    rename_regfile u_rename (
        .clk          (clk),
        .rst          (rst),
        .alloc_fire   (alloc_fire),
        .alloc        (alloc),
        .alloc_tag    (alloc_tag),
        .commit_valid (commit_valid),
        .commit       (commit),
        .flush        (flush),
        .rs_idx       (rs_idx),
        .rs_value     (rs_value),
        .rs_busy      (rs_busy),
        .rs_tag       (rs_tag)
    );

endmodule

//--- project.f
+incdir+design
design/rob_pkg.sv
design/rob_tag_alloc.sv
design/rob_entries.sv
design/rob_commit.sv
design/rename_regfile.sv
design/rob_top.sv
tb/rob_checker.sv
tb/rob_tb.sv

//--- tb/rob_checker.sv
`timescale 1ns/1ns
`include "rob_config.svh"

module rob_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [83:0]           op_word,
    input  logic                  finished,
    input  logic                  alloc_valid,
    input  rob_pkg::dispatch_t    alloc,
    input  logic                  alloc_ready,
    input  rob_pkg::rob_tag_t     alloc_tag,
    input  logic                  ex_done_valid,
    input  rob_pkg::ex_done_t     ex_done,
    input  logic                  lsu_done_valid,
    input  rob_pkg::lsu_done_t    lsu_done,
    input  logic                  commit_valid,
    input  rob_pkg::commit_t      commit,
    input  logic                  flush,
    input  logic [`XLEN-1:0]      redirect_pc,
    input  logic                  store_release,
    input  rob_pkg::rob_tag_t     store_tag,
    input  logic [`XLEN-1:0]      rs_value,
    input  logic                  rs_busy,
    input  rob_pkg::rob_tag_t     rs_tag,
    output int                    error_count,
    output int                    pending
);

    typedef struct packed {
        rob_pkg::rob_tag_t  tag;
        rob_pkg::dispatch_t disp;
        logic               released;
        logic [`XLEN-1:0]   data;
        logic               taken;
        logic [`XLEN-1:0]   target;
    } model_entry_t;

    // entries in program order with the oldest first
    model_entry_t      model_q[$];
    model_entry_t      head;
    rob_pkg::rob_tag_t model_tail;
    logic              mispredict;
    logic              in_reset = 1'b1;
    logic              summary_done = 1'b0;
    logic [3:0]        op;
    int                reset_cycles = 0;
    int                test_count = 0;
    int                fail_count = 0;
    int                test_start = 0;

    initial error_count = 0;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %h got %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic fail(input string what);
        $display("%s", what);
        error_count++;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == test_start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: failed with %0d errors", name, error_count - test_start);
            fail_count++;
        end
        test_start = error_count;
    endtask

    // newest entry with the tag gets the result
    task automatic complete(input rob_pkg::rob_tag_t tag, input logic [31:0] data,
                            input logic taken, input logic [31:0] target);
        model_entry_t e;
        for (int i = model_q.size() - 1; i >= 0; i--) begin
            if (model_q[i].tag == tag) begin
                e = model_q[i];
                e.data = data;
                e.taken = taken;
                e.target = target;
                model_q[i] = e;
                break;
            end
        end
    endtask

    always @(posedge clk) begin
        op = op_word[83:80];
        if (rst) begin
            if (reset_cycles > 0) begin
                check_value("commit_valid", 32'h0, 32'(commit_valid));
                check_value("flush", 32'h0, 32'(flush));
                check_value("store_release", 32'h0, 32'(store_release));
                check_value("rs_busy", 32'h0, 32'(rs_busy));
                check_value("rs_value", 32'h0, rs_value);
            end
            reset_cycles++;
            model_q.delete();
            model_tail = '0;
        end else begin
            if (in_reset) begin
                in_reset = 1'b0;
                end_test("reset");
            end
            if (commit_valid) begin
                if (model_q.size() == 0) begin
                    fail("commit_valid with no entry in flight");
                end else begin
                    head = model_q.pop_front();
                    if (head.disp.is_store) begin
                        fail("a store came out on the write-back port");
                    end
                    check_value("commit.tag", 32'(head.tag), 32'(commit.tag));
                    check_value("commit.rd", 32'(head.disp.rd), 32'(commit.rd));
                    check_value("commit.data", head.data, commit.data);
                    mispredict = head.disp.is_branch && (head.taken != head.disp.pred_taken);
                    check_value("flush", 32'(mispredict), 32'(flush));
                    if (mispredict) begin
                        check_value("redirect_pc", head.target, redirect_pc);
                    end
                end
            end else if (flush) begin
                fail("flush raised without a commit");
            end
            if (flush) begin
                model_q.delete();
                model_tail = '0;
            end
            if (store_release) begin
                if (model_q.size() == 0 || !model_q[0].disp.is_store || model_q[0].released) begin
                    fail("store_release with no unreleased store at the head");
                end else begin
                    check_value("store_tag", 32'(model_q[0].tag), 32'(store_tag));
                    head = model_q[0];
                    head.released = 1'b1;
                    model_q[0] = head;
                end
            end
            if (ex_done_valid) begin
                complete(ex_done.tag, ex_done.data, ex_done.taken, ex_done.target);
            end
            if (lsu_done_valid) begin
                // confirmation of the released head store retires it
                if (model_q.size() > 0 && model_q[0].released
                    && model_q[0].tag == lsu_done.tag) begin
                    void'(model_q.pop_front());
                end else begin
                    complete(lsu_done.tag, lsu_done.data, 1'b0, 32'h0);
                end
            end
            if (alloc_valid && alloc_ready) begin
                check_value("alloc_tag", 32'(model_tail), 32'(alloc_tag));
                head = '0;
                head.tag = model_tail;
                head.disp = alloc;
                model_q.push_back(head);
                model_tail = model_tail + 1'b1;
            end
            case (op)
                4'h1: begin
                    check_value("alloc_ready", 32'(op_word[4]), 32'(alloc_ready));
                    if (op_word[4]) begin
                        check_value("alloc_tag", 32'(op_word[3:0]), 32'(alloc_tag));
                    end
                end
                4'h6: check_value("alloc_ready", 32'h1, 32'(alloc_ready));
                4'h4: begin
                    check_value("rs_value", op_word[39:8], rs_value);
                    check_value("rs_busy", 32'(op_word[4]), 32'(rs_busy));
                    if (op_word[4]) begin
                        check_value("rs_tag", 32'(op_word[3:0]), 32'(rs_tag));
                    end
                end
                4'h5: end_test($sformatf("test %0d", op_word[79:72]));
                default: ;
            endcase
        end
        pending = model_q.size();
        if (finished && !summary_done) begin
            summary_done = 1'b1;
            $display("checked %0d tests, %0d failed, %0d errors",
                     test_count, fail_count, error_count);
        end
    end

endmodule

//--- tb/rob_tb.sv
`timescale 1ns/1ns
`include "rob_config.svh"

module rob_tb;

    localparam int MAX_LINES = 256;

    logic                  clk;
    logic                  rst;
    logic                  alloc_valid;
    rob_pkg::dispatch_t    alloc;
    logic                  alloc_ready;
    rob_pkg::rob_tag_t     alloc_tag;
    logic                  ex_done_valid;
    rob_pkg::ex_done_t     ex_done;
    logic                  lsu_done_valid;
    rob_pkg::lsu_done_t    lsu_done;
    logic                  commit_valid;
    rob_pkg::commit_t      commit;
    logic                  flush;
    logic [`XLEN-1:0]      redirect_pc;
    logic                  store_release;
    rob_pkg::rob_tag_t     store_tag;
    logic [`REG_IDX_W-1:0] rs_idx;
    logic [`XLEN-1:0]      rs_value;
    logic                  rs_busy;
    rob_pkg::rob_tag_t     rs_tag;
    logic [83:0]           op_word;
    logic                  finished;
    int                    error_count;
    int                    pending;
    int                    num_lines = 0;
    logic [31:0]           rand_state;
    // op, a, b, c, d fields of one operation
    logic [83:0]           tests [MAX_LINES];

    rob_top u_rob_top (.*);

    rob_checker u_checker (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic apply(input logic [83:0] word);
        alloc_valid    = 1'b0;
        alloc          = '0;
        ex_done_valid  = 1'b0;
        ex_done        = '0;
        lsu_done_valid = 1'b0;
        lsu_done       = '0;
        op_word        = word;
        case (word[83:80])
            4'h1, 4'h6: begin
                alloc_valid = 1'b1;
                alloc = rob_pkg::dispatch_t'(word[79:72]);
            end
            4'h2: begin
                ex_done_valid  = 1'b1;
                ex_done.tag    = word[75:72];
                ex_done.data   = word[71:40];
                ex_done.target = word[39:8];
                ex_done.taken  = word[0];
            end
            4'h3: begin
                lsu_done_valid = 1'b1;
                lsu_done.tag   = word[75:72];
                lsu_done.data  = word[71:40];
            end
            4'h4: rs_idx = word[76:72];
            default: ;
        endcase
    endtask

    task automatic step(input logic [83:0] word);
        @(posedge clk);
        #1;
        apply(word);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        logic [83:0] word;
        int          gap;
        rst        = 1'b1;
        finished   = 1'b0;
        rs_idx     = '0;
        rand_state = 32'h53faab99;
        apply('0);
        $readmemh("tb/rob_tests.mem", tests);
        while (num_lines < MAX_LINES && tests[num_lines][83:80] !== 4'hf
               && !$isunknown(tests[num_lines])) begin
            num_lines++;
        end
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            #1;
            rs_idx = 5'(i * 7);
        end
        rst = 1'b0;
        for (int i = 0; i < num_lines; i++) begin
            word = tests[i];
            // idle gaps ahead of the real operations
            if (word[83:80] != 4'h0 && word[83:80] != 4'h5) begin
                rand_state = xorshift(rand_state);
                gap = int'(rand_state % 3);
                repeat (gap) step('0);
            end
            if (word[83:80] == 4'h6) begin
                repeat (int'(word[4:0])) step(word);
            end else begin
                step(word);
            end
        end
        step('0);
        while (pending != 0) begin
            step('0);
        end
        finished = 1'b1;
        @(posedge clk);
        #1;
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #1;
        if (num_lines == 0) begin
            $display("no operations were read from tb/rob_tests.mem");
        end else begin
            repeat (num_lines * 40) @(posedge clk);
            $display("timeout: run still busy after %0d cycles", num_lines * 40);
        end
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- tb/rob_tests.mem
// op(1=alloc 2=ex 3=lsu 4=lookup 5=end 6=burst f=last)_a_b_c_d
// alloc a={rd,st,br,pt} d={ready,tag}; ex a=tag b=data c=target d=taken; lookup c=value d={busy,tag}
1_08_00000000_00000000_10
1_10_00000000_00000000_11
1_18_00000000_00000000_12
2_02_00000033_00000000_00
2_01_00000022_00000000_00
2_00_00000011_00000000_00
0_00_00000000_00000000_00
0_00_00000000_00000000_00
0_00_00000000_00000000_00
5_01_00000000_00000000_00
1_02_00000000_00000000_13
6_00_00000000_00000000_0F
1_00_00000000_00000000_00
2_03_00000000_00000400_01
0_00_00000000_00000000_00
0_00_00000000_00000000_00
1_00_00000000_00000000_10
2_00_000000AA_00000000_00
0_00_00000000_00000000_00
0_00_00000000_00000000_00
5_02_00000000_00000000_00
1_04_00000000_00000000_11
1_28_00000000_00000000_12
2_02_00000055_00000000_00
0_00_00000000_00000000_00
0_00_00000000_00000000_00
0_00_00000000_00000000_00
3_01_00000000_00000000_00
0_00_00000000_00000000_00
0_00_00000000_00000000_00
0_00_00000000_00000000_00
5_03_00000000_00000000_00
1_38_00000000_00000000_13
4_07_00000000_00000000_13
1_38_00000000_00000000_14
2_03_00000077_00000000_00
0_00_00000000_00000000_00
0_00_00000000_00000000_00
4_07_00000000_00000077_14
2_04_00000078_00000000_00
0_00_00000000_00000000_00
0_00_00000000_00000000_00
4_07_00000000_00000078_00
4_05_00000000_00000055_00
5_04_00000000_00000000_00
F_00_00000000_00000000_00
